//--- include/id_defines.svh
// Fixed RV32I sizes and field positions; nothing here is meant to be overridden per instance
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// Data and address width
`define ID_XLEN          32

// Register file address width
`define ID_RF_ADDR_W     5

// Source register fields in the instruction word
`define ID_RS1_MSB       19
`define ID_RS1_LSB       15
`define ID_RS2_MSB       24
`define ID_RS2_LSB       20

// Destination register field
`define ID_RD_MSB        11
`define ID_RD_LSB        7

// Hardened control flow issues every jump and branch as this many operations
`define ID_JMP_BCH_OPS   2
// Must hold values up to ID_JMP_BCH_OPS-1
`define ID_OP_CNT_W      1

`endif

//--- logic/id_pkg.sv
// Types for the RV32I decode stage only; encodings of alu_op_e and lsu_size_e are local to EX
package id_pkg;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JALR   = 7'h67,
    OPCODE_JAL    = 7'h6f
  } opcode_e;

  // ALU operations, arithmetic first and branch compares last
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Operand routing
  typedef enum logic [1:0] {A_NONE, A_REG, A_PC, A_ZERO} op_a_sel_e;
  typedef enum logic [1:0] {B_NONE, B_REG, B_IMM} op_b_sel_e;
  typedef enum logic [1:0] {IMMB_I, IMMB_S, IMMB_U, IMMB_PCINCR} imm_b_sel_e;
  typedef enum logic [1:0] {C_NONE, C_REG, C_BCH} op_c_sel_e;

  // Source of the jump target
  typedef enum logic [1:0] {SEL_JAL, SEL_JALR, SEL_BCH} bch_jmp_sel_e;

  // Forwarding source for rs1 and rs2
  typedef enum logic [1:0] {FWD_REGFILE, FWD_EX, FWD_WB} fwd_sel_e;

  // Access size, same encoding as funct3[1:0]
  typedef enum logic [1:0] {
    LSU_BYTE = 2'd0,
    LSU_HALF = 2'd1,
    LSU_WORD = 2'd2
  } lsu_size_e;

endpackage

//--- logic/id_decoder.sv
// Decodes only RV32I base integer ops; FENCE, SYSTEM, CSR and compressed words decode as illegal
`timescale 1ns/1ns
`include "id_defines.svh"

module id_decoder (
  input  logic [`ID_XLEN-1:0] instr_i,

  // Control fields
  output id_pkg::alu_op_e     alu_op_o,
  output logic                alu_en_o,
  output logic                bch_o,
  output logic                jmp_o,
  output logic                rf_we_o,
  output logic                lsu_en_o,
  output logic                lsu_we_o,
  output id_pkg::lsu_size_e   lsu_size_o,
  output logic                lsu_sext_o,
  output logic                illegal_o,

  // Mux selects
  output id_pkg::op_a_sel_e    op_a_sel_o,
  output id_pkg::op_b_sel_e    op_b_sel_o,
  output id_pkg::imm_b_sel_e   imm_b_sel_o,
  output id_pkg::op_c_sel_e    op_c_sel_o,
  output id_pkg::bch_jmp_sel_e bch_jmp_sel_o
);
  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    // Defaults describe a harmless no-op
    alu_op_o      = ALU_ADD;
    alu_en_o      = 1'b0;
    bch_o         = 1'b0;
    jmp_o         = 1'b0;
    rf_we_o       = 1'b0;
    lsu_en_o      = 1'b0;
    lsu_we_o      = 1'b0;
    lsu_size_o    = lsu_size_e'(funct3[1:0]);
    lsu_sext_o    = ~funct3[2];
    illegal_o     = 1'b0;
    op_a_sel_o    = A_NONE;
    op_b_sel_o    = B_NONE;
    imm_b_sel_o   = IMMB_I;
    op_c_sel_o    = C_NONE;
    bch_jmp_sel_o = SEL_JAL;

    case (opcode)
      //////////////////////////////////////////////////////////////////////
      // Jumps, link value pc+4 goes through the ALU
      //////////////////////////////////////////////////////////////////////
      OPCODE_JAL, OPCODE_JALR: begin
        alu_en_o      = 1'b1;
        jmp_o         = 1'b1;
        rf_we_o       = 1'b1;
        op_a_sel_o    = A_PC;
        op_b_sel_o    = B_IMM;
        imm_b_sel_o   = IMMB_PCINCR;
        bch_jmp_sel_o = (opcode == OPCODE_JAL) ? SEL_JAL : SEL_JALR;
        // JALR only defines funct3 000
        if (opcode == OPCODE_JALR && funct3 != 3'b000) illegal_o = 1'b1;
      end

      OPCODE_BRANCH: begin
        alu_en_o      = 1'b1;
        bch_o         = 1'b1;
        op_a_sel_o    = A_REG;
        op_b_sel_o    = B_REG;
        op_c_sel_o    = C_BCH;
        bch_jmp_sel_o = SEL_BCH;
        case (funct3)
          3'b000:  alu_op_o = ALU_EQ;
          3'b001:  alu_op_o = ALU_NE;
          3'b100:  alu_op_o = ALU_LT;
          3'b101:  alu_op_o = ALU_GE;
          3'b110:  alu_op_o = ALU_LTU;
          3'b111:  alu_op_o = ALU_GEU;
          default: illegal_o = 1'b1;
        endcase
      end

      //////////////////////////////////////////////////////////////////////
      // Upper immediates
      //////////////////////////////////////////////////////////////////////
      OPCODE_LUI, OPCODE_AUIPC: begin
        alu_en_o    = 1'b1;
        rf_we_o     = 1'b1;
        op_a_sel_o  = (opcode == OPCODE_LUI) ? A_ZERO : A_PC;
        op_b_sel_o  = B_IMM;
        imm_b_sel_o = IMMB_U;
      end

      //////////////////////////////////////////////////////////////////////
      // Loads and stores, address is rs1 + immediate
      //////////////////////////////////////////////////////////////////////
      OPCODE_LOAD: begin
        lsu_en_o   = 1'b1;
        rf_we_o    = 1'b1;
        op_a_sel_o = A_REG;
        op_b_sel_o = B_IMM;
        // LB LH LW LBU LHU
        if (funct3 == 3'b011 || funct3[2:1] == 2'b11) illegal_o = 1'b1;
      end

      OPCODE_STORE: begin
        lsu_en_o    = 1'b1;
        lsu_we_o    = 1'b1;
        op_a_sel_o  = A_REG;
        op_b_sel_o  = B_IMM;
        imm_b_sel_o = IMMB_S;
        // Store data travels on operand C
        op_c_sel_o  = C_REG;
        if (funct3[2] || funct3[1:0] == 2'b11) illegal_o = 1'b1;
      end

      //////////////////////////////////////////////////////////////////////
      // Register-immediate and register-register ALU ops
      //////////////////////////////////////////////////////////////////////
      OPCODE_OP_IMM: begin
        alu_en_o   = 1'b1;
        rf_we_o    = 1'b1;
        op_a_sel_o = A_REG;
        op_b_sel_o = B_IMM;
        case (funct3)
          3'b000: alu_op_o = ALU_ADD;
          3'b010: alu_op_o = ALU_SLT;
          3'b011: alu_op_o = ALU_SLTU;
          3'b100: alu_op_o = ALU_XOR;
          3'b110: alu_op_o = ALU_OR;
          3'b111: alu_op_o = ALU_AND;
          3'b001: begin
            alu_op_o = ALU_SLL;
            if (funct7 != 7'h00) illegal_o = 1'b1;
          end
          default: begin
            // SRLI or SRAI selected by bit 30
            alu_op_o = instr_i[30] ? ALU_SRA : ALU_SRL;
            if ({funct7[6], funct7[4:0]} != 6'h00) illegal_o = 1'b1;
          end
        endcase
      end

      OPCODE_OP: begin
        alu_en_o   = 1'b1;
        rf_we_o    = 1'b1;
        op_a_sel_o = A_REG;
        op_b_sel_o = B_REG;
        if ({funct7[6], funct7[4:0]} != 6'h00) illegal_o = 1'b1;
        case ({funct7[5], funct3})
          4'b0_000: alu_op_o = ALU_ADD;
          4'b1_000: alu_op_o = ALU_SUB;
          4'b0_001: alu_op_o = ALU_SLL;
          4'b0_010: alu_op_o = ALU_SLT;
          4'b0_011: alu_op_o = ALU_SLTU;
          4'b0_100: alu_op_o = ALU_XOR;
          4'b0_101: alu_op_o = ALU_SRL;
          4'b1_101: alu_op_o = ALU_SRA;
          4'b0_110: alu_op_o = ALU_OR;
          4'b0_111: alu_op_o = ALU_AND;
          default:  illegal_o = 1'b1;
        endcase
      end

      default: illegal_o = 1'b1;
    endcase

    // Illegal words must not start any unit or write the register file
    if (illegal_o) begin
      alu_en_o   = 1'b0;
      bch_o      = 1'b0;
      jmp_o      = 1'b0;
      rf_we_o    = 1'b0;
      lsu_en_o   = 1'b0;
      lsu_we_o   = 1'b0;
      op_a_sel_o = A_NONE;
      op_b_sel_o = B_NONE;
      op_c_sel_o = C_NONE;
    end
  end

endmodule

//--- logic/id_operands.sv
// Purely combinational; forwarding selects come from outside and are trusted as given
`timescale 1ns/1ns
`include "id_defines.svh"

module id_operands (
  input  logic [`ID_XLEN-1:0]   instr_i,
  input  logic [`ID_XLEN-1:0]   pc_i,

  // Selects from the decoder
  input  id_pkg::op_a_sel_e     op_a_sel_i,
  input  id_pkg::op_b_sel_e     op_b_sel_i,
  input  id_pkg::imm_b_sel_e    imm_b_sel_i,
  input  id_pkg::op_c_sel_e     op_c_sel_i,
  input  id_pkg::bch_jmp_sel_e  bch_jmp_sel_i,

  // Forwarding
  input  id_pkg::fwd_sel_e      fwd_a_sel_i,
  input  id_pkg::fwd_sel_e      fwd_b_sel_i,
  input  logic [`ID_XLEN-1:0]   rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0]   rf_rdata_b_i,
  input  logic [`ID_XLEN-1:0]   ex_wdata_i,
  input  logic [`ID_XLEN-1:0]   wb_wdata_i,

  output logic [`ID_XLEN-1:0]   operand_a_o,
  output logic [`ID_XLEN-1:0]   operand_b_o,
  output logic [`ID_XLEN-1:0]   operand_c_o,
  output logic [`ID_XLEN-1:0]   jmp_target_o
);
  import id_pkg::*;

  logic [`ID_XLEN-1:0] imm_i;
  logic [`ID_XLEN-1:0] imm_s;
  logic [`ID_XLEN-1:0] imm_sb;
  logic [`ID_XLEN-1:0] imm_u;
  logic [`ID_XLEN-1:0] imm_uj;
  logic [`ID_XLEN-1:0] imm_b;
  logic [`ID_XLEN-1:0] rs1_fw;
  logic [`ID_XLEN-1:0] rs2_fw;
  logic [`ID_XLEN-1:0] bch_target;
  logic [`ID_XLEN-1:0] jalr_sum;

  ////////////////////////////////////////////////////////////////////
  // Immediates, all sign extended from bit 31 except U
  ////////////////////////////////////////////////////////////////////
  assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_sb = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
  assign imm_u  = {instr_i[31:12], 12'b0};
  assign imm_uj = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  ////////////////////////////////////////////////////////////////////
  // Forwarding
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    case (fwd_a_sel_i)
      FWD_EX:  rs1_fw = ex_wdata_i;
      FWD_WB:  rs1_fw = wb_wdata_i;
      default: rs1_fw = rf_rdata_a_i;
    endcase
    case (fwd_b_sel_i)
      FWD_EX:  rs2_fw = ex_wdata_i;
      FWD_WB:  rs2_fw = wb_wdata_i;
      default: rs2_fw = rf_rdata_b_i;
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // Operand muxes
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    case (imm_b_sel_i)
      IMMB_S:      imm_b = imm_s;
      IMMB_U:      imm_b = imm_u;
      // Link offset, no compressed words here
      IMMB_PCINCR: imm_b = `ID_XLEN'(4);
      default:     imm_b = imm_i;
    endcase

    // NONE selects still drive the register path, EX does not capture them
    case (op_a_sel_i)
      A_PC:    operand_a_o = pc_i;
      A_ZERO:  operand_a_o = '0;
      default: operand_a_o = rs1_fw;
    endcase

    operand_b_o = (op_b_sel_i == B_IMM) ? imm_b : rs2_fw;
    operand_c_o = (op_c_sel_i == C_BCH) ? bch_target : rs2_fw;
  end

  // Branch target feeds both operand C and the jump target
  assign bch_target = pc_i + imm_sb;

  // JALR base shares the operand A forwarding select
  assign jalr_sum = rs1_fw + imm_i;

  always_comb begin
    case (bch_jmp_sel_i)
      SEL_JALR: jmp_target_o = {jalr_sum[`ID_XLEN-1:1], 1'b0};
      SEL_BCH:  jmp_target_o = bch_target;
      default:  jmp_target_o = pc_i + imm_uj;
    endcase
  end

endmodule

//--- logic/id_op_sequencer.sv
// Only place that looks at kill and halt; IF must hold its word while id_ready_o is low
`timescale 1ns/1ns
`include "id_defines.svh"

module id_op_sequencer (
  input  logic clk,
  input  logic rst_n,
  input  logic instr_valid_i,
  input  logic kill_i,
  input  logic halt_i,
  input  logic ex_ready_i,
  input  logic bch_i,
  input  logic jmp_i,
  output logic id_ready_o,
  output logic id_valid_o,
  output logic advance_o,
  output logic first_op_o,
  output logic last_op_o
);

  logic                    jmp_bch;
  logic                    multi_op_stall;
  logic [`ID_OP_CNT_W-1:0] op_cnt;

  // Every jump and branch runs as a multi-op sequence
  assign jmp_bch = bch_i | jmp_i;

  assign first_op_o = jmp_bch ? (op_cnt == '0) : 1'b1;
  assign last_op_o  = jmp_bch ? (op_cnt == `ID_OP_CNT_W'(`ID_JMP_BCH_OPS - 1)) : 1'b1;

  // Keep IF out while operations of the current instruction remain
  assign multi_op_stall = ~last_op_o & instr_valid_i;

  ////////////////////////////////////////////////////////////////////
  // Stage handshake
  ////////////////////////////////////////////////////////////////////
  assign id_valid_o = instr_valid_i & ~kill_i & ~halt_i;
  assign advance_o  = id_valid_o & ex_ready_i;
  // Kill frees the stage even mid sequence
  assign id_ready_o = kill_i | (~multi_op_stall & ex_ready_i & ~halt_i);

  // Operation counter
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      op_cnt <= '0;
    end else if (kill_i) begin
      op_cnt <= '0;
    end else if (advance_o) begin
      // Wrap after the last operation
      op_cnt <= last_op_o ? '0 : op_cnt + `ID_OP_CNT_W'(1);
    end
  end

endmodule

//--- logic/id_ex_regs.sv
// Fields of units that an instruction does not use keep stale values; qualify them with the enables
`timescale 1ns/1ns
`include "id_defines.svh"

module id_ex_regs (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    advance_i,
  input  logic                    ex_ready_i,

  // Decoder fields
  input  id_pkg::alu_op_e         alu_op_i,
  input  logic                    alu_en_i,
  input  logic                    bch_i,
  input  logic                    jmp_i,
  input  logic                    rf_we_i,
  input  logic                    lsu_en_i,
  input  logic                    lsu_we_i,
  input  id_pkg::lsu_size_e       lsu_size_i,
  input  logic                    lsu_sext_i,
  input  logic                    illegal_i,
  input  id_pkg::op_a_sel_e       op_a_sel_i,
  input  id_pkg::op_b_sel_e       op_b_sel_i,
  input  id_pkg::op_c_sel_e       op_c_sel_i,

  // Datapath
  input  logic [`ID_XLEN-1:0]     operand_a_i,
  input  logic [`ID_XLEN-1:0]     operand_b_i,
  input  logic [`ID_XLEN-1:0]     operand_c_i,
  input  logic [`ID_XLEN-1:0]     pc_i,
  input  logic [`ID_RF_ADDR_W-1:0] rd_i,
  input  logic                    first_op_i,
  input  logic                    last_op_i,

  output logic                    ex_valid_o,
  output id_pkg::alu_op_e         ex_alu_op_o,
  output logic [`ID_XLEN-1:0]     ex_operand_a_o,
  output logic [`ID_XLEN-1:0]     ex_operand_b_o,
  output logic [`ID_XLEN-1:0]     ex_operand_c_o,
  output logic                    ex_rf_we_o,
  output logic [`ID_RF_ADDR_W-1:0] ex_rf_waddr_o,
  output logic                    ex_lsu_en_o,
  output logic                    ex_lsu_we_o,
  output id_pkg::lsu_size_e       ex_lsu_size_o,
  output logic                    ex_lsu_sext_o,
  output logic                    ex_bch_o,
  output logic                    ex_jmp_o,
  output logic                    ex_illegal_o,
  output logic                    ex_first_op_o,
  output logic                    ex_last_op_o,
  output logic [`ID_XLEN-1:0]     ex_pc_o
);
  import id_pkg::*;

  ////////////////////////////////////////////////////////////////////
  // Control state
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      ex_valid_o    <= 1'b0;
      ex_alu_op_o   <= ALU_SLTU;
      ex_rf_we_o    <= 1'b0;
      ex_lsu_en_o   <= 1'b0;
      ex_bch_o      <= 1'b0;
      ex_jmp_o      <= 1'b0;
      ex_illegal_o  <= 1'b0;
      ex_first_op_o <= 1'b0;
      ex_last_op_o  <= 1'b0;
    end else if (advance_i) begin
      ex_valid_o    <= 1'b1;
      ex_rf_we_o    <= rf_we_i;
      ex_lsu_en_o   <= lsu_en_i;
      ex_bch_o      <= bch_i;
      ex_jmp_o      <= jmp_i;
      ex_illegal_o  <= illegal_i;
      ex_first_op_o <= first_op_i;
      ex_last_op_o  <= last_op_i;
      if (alu_en_i) ex_alu_op_o <= alu_op_i;
    end else if (ex_ready_i) begin
      // EX consumed its entry and ID had nothing, so insert a bubble
      ex_valid_o <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Payload, captured only where the instruction uses it
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (advance_i) begin
      ex_pc_o <= pc_i;
      if (op_a_sel_i != A_NONE) ex_operand_a_o <= operand_a_i;
      if (op_b_sel_i != B_NONE) ex_operand_b_o <= operand_b_i;
      // Store data or branch target
      if (op_c_sel_i != C_NONE) ex_operand_c_o <= operand_c_i;
      if (lsu_en_i) begin
        ex_lsu_we_o   <= lsu_we_i;
        ex_lsu_size_o <= lsu_size_i;
        ex_lsu_sext_o <= lsu_sext_i;
      end
      if (rf_we_i) ex_rf_waddr_o <= rd_i;
    end
  end

endmodule

//--- logic/id_stage.sv
// RV32I decode stage with hardened jumps and branches; single clock, forwarding decided outside
`timescale 1ns/1ns
`include "id_defines.svh"

module id_stage (
  input  logic                     clk,
  input  logic                     rst_n,

  // From IF and the controller
  input  logic                     instr_valid_i,
  input  logic [`ID_XLEN-1:0]      instr_i,
  input  logic [`ID_XLEN-1:0]      pc_i,
  input  logic                     kill_i,
  input  logic                     halt_i,
  input  id_pkg::fwd_sel_e         fwd_a_sel_i,
  input  id_pkg::fwd_sel_e         fwd_b_sel_i,

  // Register file and bypass data
  input  logic [`ID_XLEN-1:0]      rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0]      rf_rdata_b_i,
  input  logic [`ID_XLEN-1:0]      ex_wdata_i,
  input  logic [`ID_XLEN-1:0]      wb_wdata_i,
  input  logic                     ex_ready_i,

  output logic [`ID_RF_ADDR_W-1:0] rf_raddr_a_o,
  output logic [`ID_RF_ADDR_W-1:0] rf_raddr_b_o,
  output logic                     id_ready_o,
  output logic [`ID_XLEN-1:0]      jmp_target_o,

  // ID/EX register
  output logic                     ex_valid_o,
  output id_pkg::alu_op_e          ex_alu_op_o,
  output logic [`ID_XLEN-1:0]      ex_operand_a_o,
  output logic [`ID_XLEN-1:0]      ex_operand_b_o,
  output logic [`ID_XLEN-1:0]      ex_operand_c_o,
  output logic                     ex_rf_we_o,
  output logic [`ID_RF_ADDR_W-1:0] ex_rf_waddr_o,
  output logic                     ex_lsu_en_o,
  output logic                     ex_lsu_we_o,
  output id_pkg::lsu_size_e        ex_lsu_size_o,
  output logic                     ex_lsu_sext_o,
  output logic                     ex_bch_o,
  output logic                     ex_jmp_o,
  output logic                     ex_illegal_o,
  output logic                     ex_first_op_o,
  output logic                     ex_last_op_o,
  output logic [`ID_XLEN-1:0]      ex_pc_o
);
  import id_pkg::*;

  // Decoder outputs
  alu_op_e       alu_op;
  logic          alu_en, bch, jmp, rf_we, illegal;
  logic          lsu_en, lsu_we, lsu_sext;
  lsu_size_e     lsu_size;
  op_a_sel_e     op_a_sel;
  op_b_sel_e     op_b_sel;
  imm_b_sel_e    imm_b_sel;
  op_c_sel_e     op_c_sel;
  bch_jmp_sel_e  bch_jmp_sel;

  // Operand path and sequencer
  logic [`ID_XLEN-1:0]      operand_a, operand_b, operand_c;
  logic [`ID_RF_ADDR_W-1:0] rd;
  logic                     advance, first_op, last_op;

  // Register fields straight from the word
  assign rf_raddr_a_o = instr_i[`ID_RS1_MSB:`ID_RS1_LSB];
  assign rf_raddr_b_o = instr_i[`ID_RS2_MSB:`ID_RS2_LSB];
  assign rd           = instr_i[`ID_RD_MSB:`ID_RD_LSB];

  id_decoder i_decoder (
    .instr_i(instr_i), .alu_op_o(alu_op), .alu_en_o(alu_en), .bch_o(bch), .jmp_o(jmp),
    .rf_we_o(rf_we), .lsu_en_o(lsu_en), .lsu_we_o(lsu_we), .lsu_size_o(lsu_size),
    .lsu_sext_o(lsu_sext), .illegal_o(illegal), .op_a_sel_o(op_a_sel),
    .op_b_sel_o(op_b_sel), .imm_b_sel_o(imm_b_sel), .op_c_sel_o(op_c_sel),
    .bch_jmp_sel_o(bch_jmp_sel)
  );

  id_operands i_operands (
    .instr_i(instr_i), .pc_i(pc_i), .op_a_sel_i(op_a_sel), .op_b_sel_i(op_b_sel),
    .imm_b_sel_i(imm_b_sel), .op_c_sel_i(op_c_sel), .bch_jmp_sel_i(bch_jmp_sel),
    .fwd_a_sel_i(fwd_a_sel_i), .fwd_b_sel_i(fwd_b_sel_i), .rf_rdata_a_i(rf_rdata_a_i),
    .rf_rdata_b_i(rf_rdata_b_i), .ex_wdata_i(ex_wdata_i), .wb_wdata_i(wb_wdata_i),
    .operand_a_o(operand_a), .operand_b_o(operand_b), .operand_c_o(operand_c),
    .jmp_target_o(jmp_target_o)
  );

  // id_valid is consumed inside the sequencer as part of advance
  id_op_sequencer i_op_sequencer (
    .clk(clk), .rst_n(rst_n), .instr_valid_i(instr_valid_i), .kill_i(kill_i),
    .halt_i(halt_i), .ex_ready_i(ex_ready_i), .bch_i(bch), .jmp_i(jmp),
    .id_ready_o(id_ready_o), .id_valid_o(), .advance_o(advance),
    .first_op_o(first_op), .last_op_o(last_op)
  );

  id_ex_regs i_ex_regs (
    .clk(clk), .rst_n(rst_n), .advance_i(advance), .ex_ready_i(ex_ready_i),
    .alu_op_i(alu_op), .alu_en_i(alu_en), .bch_i(bch), .jmp_i(jmp), .rf_we_i(rf_we),
    .lsu_en_i(lsu_en), .lsu_we_i(lsu_we), .lsu_size_i(lsu_size), .lsu_sext_i(lsu_sext),
    .illegal_i(illegal), .op_a_sel_i(op_a_sel), .op_b_sel_i(op_b_sel),
    .op_c_sel_i(op_c_sel), .operand_a_i(operand_a), .operand_b_i(operand_b),
    .operand_c_i(operand_c), .pc_i(pc_i), .rd_i(rd), .first_op_i(first_op),
    .last_op_i(last_op), .ex_valid_o(ex_valid_o), .ex_alu_op_o(ex_alu_op_o),
    .ex_operand_a_o(ex_operand_a_o), .ex_operand_b_o(ex_operand_b_o),
    .ex_operand_c_o(ex_operand_c_o), .ex_rf_we_o(ex_rf_we_o),
    .ex_rf_waddr_o(ex_rf_waddr_o), .ex_lsu_en_o(ex_lsu_en_o),
    .ex_lsu_we_o(ex_lsu_we_o), .ex_lsu_size_o(ex_lsu_size_o),
    .ex_lsu_sext_o(ex_lsu_sext_o), .ex_bch_o(ex_bch_o), .ex_jmp_o(ex_jmp_o),
    .ex_illegal_o(ex_illegal_o), .ex_first_op_o(ex_first_op_o),
    .ex_last_op_o(ex_last_op_o), .ex_pc_o(ex_pc_o)
  );

endmodule

//--- testbench/tb_id_stage.sv
// Runs one instruction per table row with ex_ready high except in back-pressure rows; needs timing support
`timescale 1ns/1ns
`include "id_defines.svh"

module tb_id_stage;
  import id_pkg::*;

  localparam int N_ROWS = 18;
  localparam int M_NORM = 0;
  localparam int M_BP   = 1;
  localparam int M_KILL = 2;

  logic clk, rst_n, instr_valid, kill, halt, ex_ready;
  logic [`ID_XLEN-1:0] instr, pc, rf_a, rf_b, ex_w, wb_w;
  fwd_sel_e fwd_a, fwd_b;
  logic [`ID_RF_ADDR_W-1:0] raddr_a, raddr_b, ex_waddr;
  logic id_ready, ex_valid, ex_rf_we, ex_lsu_en, ex_lsu_we, ex_lsu_sext;
  logic ex_bch, ex_jmp, ex_illegal, ex_first, ex_last;
  logic [`ID_XLEN-1:0] jmp_target, ex_a, ex_b, ex_c, ex_pc;
  alu_op_e ex_alu_op;
  lsu_size_e ex_lsu_size;

  // Stimulus table with the few expected fields that cannot be derived from the word
  logic [31:0] t_instr [N_ROWS];
  logic [31:0] t_pc [N_ROWS];
  fwd_sel_e t_fa [N_ROWS];
  fwd_sel_e t_fb [N_ROWS];
  int t_mode [N_ROWS];
  alu_op_e t_alu [N_ROWS];
  logic t_alu_chk [N_ROWS];

  // Expected values of the current row
  logic [31:0] e_a, e_b, e_c, e_tgt;
  logic e_c_chk, e_tgt_chk, e_rf_we, e_lsu_en, e_lsu_we, e_bch, e_jmp, e_ill;
  int n_checks, n_errors;

  id_stage i_dut (
    .clk(clk), .rst_n(rst_n), .instr_valid_i(instr_valid), .instr_i(instr), .pc_i(pc),
    .kill_i(kill), .halt_i(halt), .fwd_a_sel_i(fwd_a), .fwd_b_sel_i(fwd_b),
    .rf_rdata_a_i(rf_a), .rf_rdata_b_i(rf_b), .ex_wdata_i(ex_w), .wb_wdata_i(wb_w),
    .ex_ready_i(ex_ready), .rf_raddr_a_o(raddr_a), .rf_raddr_b_o(raddr_b),
    .id_ready_o(id_ready), .jmp_target_o(jmp_target), .ex_valid_o(ex_valid),
    .ex_alu_op_o(ex_alu_op), .ex_operand_a_o(ex_a), .ex_operand_b_o(ex_b),
    .ex_operand_c_o(ex_c), .ex_rf_we_o(ex_rf_we), .ex_rf_waddr_o(ex_waddr),
    .ex_lsu_en_o(ex_lsu_en), .ex_lsu_we_o(ex_lsu_we), .ex_lsu_size_o(ex_lsu_size),
    .ex_lsu_sext_o(ex_lsu_sext), .ex_bch_o(ex_bch), .ex_jmp_o(ex_jmp),
    .ex_illegal_o(ex_illegal), .ex_first_op_o(ex_first), .ex_last_op_o(ex_last),
    .ex_pc_o(ex_pc)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Watchdog sized from the table length
  initial begin
    #(N_ROWS * 10 * 8 + 8 * 8);
    $display("Timeout: the DUT did not finish the table in time");
    $display("CHECKS FAILED");
    $finish;
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      n_errors++;
    end
  endtask

  task automatic add_row(input int r, input logic [31:0] w, input logic [31:0] p,
                         input fwd_sel_e fa, input fwd_sel_e fb, input int mode,
                         input alu_op_e op, input logic chk);
    t_instr[r] = w;
    t_pc[r] = p;
    t_fa[r] = fa;
    t_fb[r] = fb;
    t_mode[r] = mode;
    t_alu[r] = op;
    t_alu_chk[r] = chk;
  endtask

  function automatic logic [31:0] fwd_val(input fwd_sel_e s, input logic [31:0] rf);
    if (s == FWD_EX) return ex_w;
    if (s == FWD_WB) return wb_w;
    return rf;
  endfunction

  // Operand and target rules of RV32I, written from the ISA encodings
  task automatic compute_expected(input int r);
    logic [31:0] w, p, rs1, rs2, imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [6:0] opc;
    w = t_instr[r];
    p = t_pc[r];
    opc = w[6:0];
    rs1 = fwd_val(t_fa[r], rf_a);
    rs2 = fwd_val(t_fb[r], rf_b);
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {w[31:12], 12'h000};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    e_ill = !(opc inside {7'h03, 7'h13, 7'h17, 7'h23, 7'h33, 7'h37, 7'h63, 7'h67, 7'h6f});
    e_rf_we = opc inside {7'h03, 7'h13, 7'h17, 7'h33, 7'h37, 7'h67, 7'h6f};
    e_lsu_en = opc inside {7'h03, 7'h23};
    e_lsu_we = (opc == 7'h23);
    e_bch = (opc == 7'h63);
    e_jmp = (opc == 7'h67) || (opc == 7'h6f);
    e_a = (opc == 7'h37) ? 32'h0 : (opc inside {7'h17, 7'h67, 7'h6f}) ? p : rs1;
    case (opc)
      7'h33, 7'h63: e_b = rs2;
      7'h23: e_b = imm_s;
      7'h17, 7'h37: e_b = imm_u;
      7'h67, 7'h6f: e_b = 32'd4;
      default: e_b = imm_i;
    endcase
    e_c_chk = (opc == 7'h23) || e_bch;
    e_c = e_bch ? p + imm_b : rs2;
    e_tgt_chk = e_bch || e_jmp;
    e_tgt = e_bch ? p + imm_b : (opc == 7'h6f) ? p + imm_j : (rs1 + imm_i) & ~32'h1;
  endtask

  task automatic check_ex(input int r, input int op, input int nops);
    check_val("ex_valid_o", ex_valid, 1);
    check_val("ex_first_op_o", ex_first, op == 0);
    check_val("ex_last_op_o", ex_last, op == nops - 1);
    check_val("ex_pc_o", ex_pc, t_pc[r]);
    check_val("ex_illegal_o", ex_illegal, e_ill);
    check_val("ex_rf_we_o", ex_rf_we, e_rf_we);
    check_val("ex_lsu_en_o", ex_lsu_en, e_lsu_en);
    check_val("ex_bch_o", ex_bch, e_bch);
    check_val("ex_jmp_o", ex_jmp, e_jmp);
    if (e_ill) return;
    check_val("ex_operand_a_o", ex_a, e_a);
    check_val("ex_operand_b_o", ex_b, e_b);
    if (e_c_chk) check_val("ex_operand_c_o", ex_c, e_c);
    if (t_alu_chk[r]) check_val("ex_alu_op_o", ex_alu_op, t_alu[r]);
    if (e_rf_we) check_val("ex_rf_waddr_o", ex_waddr, t_instr[r][11:7]);
    if (e_lsu_en) begin
      check_val("ex_lsu_we_o", ex_lsu_we, e_lsu_we);
      check_val("ex_lsu_size_o", ex_lsu_size, t_instr[r][13:12]);
      check_val("ex_lsu_sext_o", ex_lsu_sext, !t_instr[r][14]);
    end
  endtask

  task automatic run_row(input int r);
    int nops;
    logic [31:0] snap_a, snap_pc;
    compute_expected(r);
    nops = (e_bch || e_jmp) ? `ID_JMP_BCH_OPS : 1;
    @(posedge clk);
    instr_valid <= 1'b1;
    instr <= t_instr[r];
    pc <= t_pc[r];
    fwd_a <= t_fa[r];
    fwd_b <= t_fb[r];
    if (t_mode[r] == M_BP) begin
      ex_ready <= 1'b0;
      @(negedge clk);
      snap_a = ex_a;
      snap_pc = ex_pc;
      repeat (2) begin
        @(negedge clk);
        check_val("id_ready_o", id_ready, 0);
        check_val("ex_valid_o", ex_valid, 0);
        check_val("ex_operand_a_o", ex_a, snap_a);
        check_val("ex_pc_o", ex_pc, snap_pc);
      end
      @(posedge clk);
      ex_ready <= 1'b1;
    end
    @(negedge clk);
    // Register file addresses come from the rs1 and rs2 fields
    check_val("rf_raddr_a_o", raddr_a, t_instr[r][19:15]);
    check_val("rf_raddr_b_o", raddr_b, t_instr[r][24:20]);
    for (int op = 0; op < nops; op++) begin
      // First operation of a jump or branch keeps IF stalled
      check_val("id_ready_o", id_ready, !(nops > 1 && op == 0));
      if (e_tgt_chk) check_val("jmp_target_o", jmp_target, e_tgt);
      @(posedge clk);
      if (op == nops - 1) instr_valid <= 1'b0;
      if (t_mode[r] == M_KILL && op == 0) kill <= 1'b1;
      @(negedge clk);
      check_ex(r, op, nops);
      if (t_mode[r] == M_KILL && op == 0) begin
        // Kill frees the stage and drops the second operation
        check_val("id_ready_o", id_ready, 1);
        @(posedge clk);
        kill <= 1'b0;
        instr_valid <= 1'b0;
        @(negedge clk);
        check_val("ex_valid_o", ex_valid, 0);
        return;
      end
    end
  endtask

  initial begin
    n_checks = 0;
    n_errors = 0;
    void'($urandom(33));
    rst_n <= 1'b0;
    instr_valid <= 1'b0;
    instr <= 32'h0;
    pc <= 32'h0;
    kill <= 1'b0;
    halt <= 1'b0;
    ex_ready <= 1'b1;
    fwd_a <= FWD_REGFILE;
    fwd_b <= FWD_REGFILE;
    rf_a <= $urandom();
    rf_b <= $urandom();
    ex_w <= $urandom();
    wb_w <= $urandom();

    add_row(0, 32'h002081B3, 32'h0000_0100, FWD_REGFILE, FWD_REGFILE, M_NORM, ALU_ADD, 1);
    add_row(1, 32'h002081B3, 32'h0000_0104, FWD_EX, FWD_WB, M_NORM, ALU_ADD, 1);
    add_row(2, 32'h002081B3, 32'h0000_0108, FWD_WB, FWD_EX, M_BP, ALU_ADD, 1);
    add_row(3, 32'h402081B3, 32'h0000_010C, FWD_EX, FWD_REGFILE, M_NORM, ALU_SUB, 1);
    add_row(4, 32'hFFB08193, 32'h0000_0110, FWD_WB, FWD_REGFILE, M_NORM, ALU_ADD, 1);
    add_row(5, 32'h123451B7, 32'h0000_0114, FWD_REGFILE, FWD_REGFILE, M_NORM, ALU_ADD, 1);
    add_row(6, 32'hABCDE197, 32'h0000_1000, FWD_REGFILE, FWD_REGFILE, M_NORM, ALU_ADD, 1);
    add_row(7, 32'h0100A183, 32'h0000_1004, FWD_EX, FWD_REGFILE, M_NORM, ALU_ADD, 0);
    add_row(8, 32'hFFF0C183, 32'h0000_1008, FWD_REGFILE, FWD_REGFILE, M_NORM, ALU_ADD, 0);
    add_row(9, 32'h0020A423, 32'h0000_100C, FWD_REGFILE, FWD_REGFILE, M_NORM, ALU_ADD, 0);
    add_row(10, 32'hFE209E23, 32'h0000_1010, FWD_EX, FWD_WB, M_NORM, ALU_ADD, 0);
    add_row(11, 32'h100000EF, 32'h0000_2000, FWD_REGFILE, FWD_REGFILE, M_KILL, ALU_ADD, 1);
    add_row(12, 32'h00208863, 32'h0000_2100, FWD_REGFILE, FWD_EX, M_NORM, ALU_EQ, 1);
    add_row(13, 32'h100000EF, 32'h0000_2200, FWD_REGFILE, FWD_REGFILE, M_NORM, ALU_ADD, 1);
    add_row(14, 32'h007081E7, 32'h0000_2300, FWD_EX, FWD_REGFILE, M_NORM, ALU_ADD, 1);
    add_row(15, 32'hFE20ECE3, 32'h0000_2400, FWD_WB, FWD_REGFILE, M_NORM, ALU_LTU, 1);
    add_row(16, 32'h0000000B, 32'h0000_2500, FWD_REGFILE, FWD_REGFILE, M_NORM, ALU_ADD, 0);
    add_row(17, 32'h002081B3, 32'h0000_2504, FWD_REGFILE, FWD_WB, M_NORM, ALU_ADD, 1);

    repeat (4) @(posedge clk);
    @(negedge clk);
    // Control outputs held clear under reset
    check_val("ex_valid_o", ex_valid, 0);
    check_val("ex_rf_we_o", ex_rf_we, 0);
    check_val("ex_lsu_en_o", ex_lsu_en, 0);
    check_val("ex_bch_o", ex_bch, 0);
    check_val("ex_jmp_o", ex_jmp, 0);
    check_val("ex_illegal_o", ex_illegal, 0);
    check_val("ex_first_op_o", ex_first, 0);
    check_val("ex_last_op_o", ex_last, 0);
    @(posedge clk);
    rst_n <= 1'b1;

    for (int r = 0; r < N_ROWS; r++) run_row(r);

    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+include
logic/id_pkg.sv
logic/id_decoder.sv
logic/id_operands.sv
logic/id_op_sequencer.sv
logic/id_ex_regs.sv
logic/id_stage.sv
testbench/tb_id_stage.sv

//--- Makefile
# Verilator build and run of the ID stage testbench

TOP := tb_id_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
